// ==== verilog/dbg_pkg.sv ====
package dbg_pkg;

  // Serial bits are kept short so that simulation stays fast
  localparam int clks_per_bit = 8;
  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

  // The receiver sees the line two cycles late through its synchronizer,
  // so the half-bit count is shortened to land on the true middle
  localparam logic [cnt_w-1:0] bit_half = cnt_w'(clks_per_bit / 2 - 2);

  // GPIO bank geometry
  localparam int num_slots = 4;
  localparam int slot_w = 2;
  localparam int data_w = 8;

  // Bits 5:2 of the command byte carry no meaning
  localparam int cmd_write_bit = 7;
  localparam int cmd_input_bit = 6;

  // Bridge FSM encodings
  localparam int st_w = 3;
  localparam logic [st_w-1:0] st_idle = 3'd0;
  localparam logic [st_w-1:0] st_wait_data = 3'd1;
  localparam logic [st_w-1:0] st_rd_issue = 3'd2;
  localparam logic [st_w-1:0] st_rd_wait = 3'd3;
  localparam logic [st_w-1:0] st_send = 3'd4;

endpackage

// ==== verilog/io_bus_if.sv ====
`timescale 1ns/100ps

interface io_bus_if;

  // Single-cycle strobes from the bridge
  logic wen;
  logic ren;

  // Target slot and source select, held from the last command byte
  logic [dbg_pkg::slot_w-1:0] slot;
  logic sel_in;

  logic [dbg_pkg::data_w-1:0] wdata;
  logic [dbg_pkg::data_w-1:0] rdata;
  logic rdata_valid;

  modport bridge_mp (
    output wen, ren, slot, sel_in, wdata,
    input rdata, rdata_valid
  );

  modport slot_mp (
    input wen, slot, wdata
  );

  modport mux_mp (
    input ren, slot, sel_in,
    output rdata, rdata_valid
  );

endinterface

// ==== verilog/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
  input  logic       clk,
  input  logic       reset,
  input  logic       urx_pin,
  output logic       urx_valid,
  output logic [7:0] urx_data,
  input  logic       urx_ready
);

  logic [1:0] pin_sync;
  logic rx_s;
  logic busy;
  logic [dbg_pkg::cnt_w-1:0] cnt;
  // Frame position 0 is the start bit, 1 to 8 are the data bits and 9 is the stop bit
  logic [3:0] bit_idx;
  logic [7:0] shift_q;

  assign rx_s = pin_sync[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      pin_sync <= 2'b11;
    end else begin
      pin_sync <= {pin_sync[0], urx_pin};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      cnt <= '0;
      bit_idx <= 4'd0;
      urx_valid <= 1'b0;
    end else begin
      if (urx_valid && urx_ready) begin
        urx_valid <= 1'b0;
      end
      if (!busy) begin
        // A low level on an idle line is taken as a start edge
        if (!rx_s) begin
          busy <= 1'b1;
          cnt <= '0;
          bit_idx <= 4'd0;
        end
      end else if (bit_idx == 4'd0) begin
        if (cnt == dbg_pkg::bit_half) begin
          cnt <= '0;
          if (rx_s) begin
            // A line that is back high by mid start bit was only a glitch
            busy <= 1'b0;
          end else begin
            bit_idx <= 4'd1;
          end
        end else begin
          cnt <= cnt + 1'b1;
        end
      end else if (cnt == dbg_pkg::bit_last) begin
        cnt <= '0;
        if (bit_idx == 4'd9) begin
          busy <= 1'b0;
          // A byte finished while the last one is still pending is lost
          if (rx_s && !urx_valid) begin
            urx_valid <= 1'b1;
          end
        end else begin
          bit_idx <= bit_idx + 4'd1;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (busy && bit_idx != 4'd0 && cnt == dbg_pkg::bit_last) begin
      if (bit_idx == 4'd9) begin
        if (rx_s && !urx_valid) begin
          urx_data <= shift_q;
        end
      end else begin
        shift_q <= {rx_s, shift_q[7:1]};
      end
    end
  end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic       utx_valid,
  input  logic [7:0] utx_data,
  output logic       utx_ready,
  output logic       utx_pin
);

  logic busy;
  logic [dbg_pkg::cnt_w-1:0] cnt;
  logic [3:0] bits_left;
  // Stop bit, data LSB first, start bit in position 0
  logic [9:0] frame_q;

  assign utx_ready = !busy;

  // The line idles high between frames
  assign utx_pin = busy ? frame_q[0] : 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      cnt <= '0;
      bits_left <= 4'd0;
    end else if (!busy) begin
      if (utx_valid) begin
        busy <= 1'b1;
        cnt <= '0;
        bits_left <= 4'd10;
      end
    end else if (cnt == dbg_pkg::bit_last) begin
      cnt <= '0;
      bits_left <= bits_left - 4'd1;
      if (bits_left == 4'd1) begin
        busy <= 1'b0;
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && utx_valid) begin
      frame_q <= {1'b1, utx_data, 1'b0};
    end else if (busy && cnt == dbg_pkg::bit_last) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

endmodule

// ==== verilog/dbg_bridge.sv ====
`timescale 1ns/100ps

module dbg_bridge (
  input  logic       clk,
  input  logic       reset,
  input  logic       urx_valid,
  input  logic [7:0] urx_data,
  output logic       urx_ready,
  output logic       utx_valid,
  output logic [7:0] utx_data,
  input  logic       utx_ready,
  io_bus_if.bridge_mp bus
);

  logic [dbg_pkg::st_w-1:0] state;
  logic [dbg_pkg::slot_w-1:0] cmd_slot;
  logic cmd_sel_in;
  // Holds the write data byte, and later the read reply for the transmitter
  logic [dbg_pkg::data_w-1:0] data_q;

  // Bytes are only taken while no read is outstanding
  assign urx_ready = (state == dbg_pkg::st_idle) || (state == dbg_pkg::st_wait_data);
  assign utx_valid = (state == dbg_pkg::st_send);
  assign utx_data = data_q;

  assign bus.slot = cmd_slot;
  assign bus.sel_in = cmd_sel_in;
  assign bus.wdata = data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= dbg_pkg::st_idle;
      bus.wen <= 1'b0;
      bus.ren <= 1'b0;
    end else begin
      bus.wen <= 1'b0;
      bus.ren <= 1'b0;
      case (state)
        dbg_pkg::st_idle: begin
          if (urx_valid) begin
            if (urx_data[dbg_pkg::cmd_write_bit]) begin
              state <= dbg_pkg::st_wait_data;
            end else begin
              bus.ren <= 1'b1;
              state <= dbg_pkg::st_rd_issue;
            end
          end
        end
        dbg_pkg::st_wait_data: begin
          if (urx_valid) begin
            bus.wen <= 1'b1;
            state <= dbg_pkg::st_idle;
          end
        end
        // The ren pulse is on the bus during this state
        dbg_pkg::st_rd_issue: state <= dbg_pkg::st_rd_wait;
        dbg_pkg::st_rd_wait: begin
          if (bus.rdata_valid) begin
            state <= dbg_pkg::st_send;
          end
        end
        dbg_pkg::st_send: begin
          if (utx_ready) begin
            state <= dbg_pkg::st_idle;
          end
        end
        default: state <= dbg_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == dbg_pkg::st_idle && urx_valid) begin
      cmd_slot <= urx_data[dbg_pkg::slot_w-1:0];
      cmd_sel_in <= urx_data[dbg_pkg::cmd_input_bit];
    end
    if (state == dbg_pkg::st_wait_data && urx_valid) begin
      data_q <= urx_data;
    end else if (state == dbg_pkg::st_rd_wait && bus.rdata_valid) begin
      data_q <= bus.rdata;
    end
  end

endmodule

// ==== verilog/io_slot.sv ====
`timescale 1ns/100ps

module io_slot #(
  parameter logic [dbg_pkg::slot_w-1:0] slot_id = '0
) (
  input  logic                       clk,
  input  logic                       reset,
  io_bus_if.slot_mp                  bus,
  input  logic [dbg_pkg::data_w-1:0] pin_in,
  output logic [dbg_pkg::data_w-1:0] pin_out,
  output logic [dbg_pkg::data_w-1:0] in_sync
);

  logic hit;
  logic [dbg_pkg::data_w-1:0] in_meta;

  // Each slot decodes its own address off the shared bus
  assign hit = bus.wen && (bus.slot == slot_id);

  always_ff @(posedge clk) begin
    if (reset) begin
      pin_out <= '0;
    end else if (hit) begin
      pin_out <= bus.wdata;
    end
  end

  // Board pins are asynchronous and pass two flops before anything reads them
  always_ff @(posedge clk) begin
    in_meta <= pin_in;
    in_sync <= in_meta;
  end

endmodule

// ==== verilog/io_read_mux.sv ====
`timescale 1ns/100ps

module io_read_mux (
  input logic                       clk,
  input logic                       reset,
  io_bus_if.mux_mp                  bus,
  input logic [dbg_pkg::data_w-1:0] out_regs [dbg_pkg::num_slots],
  input logic [dbg_pkg::data_w-1:0] in_regs  [dbg_pkg::num_slots]
);

  always_ff @(posedge clk) begin
    if (reset) begin
      bus.rdata_valid <= 1'b0;
    end else begin
      bus.rdata_valid <= bus.ren;
    end
  end

  // sel_in picks the pin side over the output register
  always_ff @(posedge clk) begin
    if (bus.ren) begin
      if (bus.sel_in) begin
        bus.rdata <= in_regs[bus.slot];
      end else begin
        bus.rdata <= out_regs[bus.slot];
      end
    end
  end

endmodule

// ==== verilog/dbg_io_top.sv ====
`timescale 1ns/100ps

module dbg_io_top (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         uart_rx_pin,
  output logic                                         uart_tx_pin,
  input  logic [dbg_pkg::num_slots*dbg_pkg::data_w-1:0] gpio_in,
  output wire  [dbg_pkg::num_slots*dbg_pkg::data_w-1:0] gpio_out
);

  logic urx_valid;
  logic [7:0] urx_data;
  logic urx_ready;
  logic utx_valid;
  logic [7:0] utx_data;
  logic utx_ready;

  logic [dbg_pkg::data_w-1:0] out_regs [dbg_pkg::num_slots];
  logic [dbg_pkg::data_w-1:0] in_regs [dbg_pkg::num_slots];

  io_bus_if bus ();

  uart_rx uart_rx_i (
    .clk      (clk),
    .reset    (reset),
    .urx_pin  (uart_rx_pin),
    .urx_valid(urx_valid),
    .urx_data (urx_data),
    .urx_ready(urx_ready)
  );

  uart_tx uart_tx_i (
    .clk      (clk),
    .reset    (reset),
    .utx_valid(utx_valid),
    .utx_data (utx_data),
    .utx_ready(utx_ready),
    .utx_pin  (uart_tx_pin)
  );

  dbg_bridge bridge_i (
    .clk      (clk),
    .reset    (reset),
    .urx_valid(urx_valid),
    .urx_data (urx_data),
    .urx_ready(urx_ready),
    .utx_valid(utx_valid),
    .utx_data (utx_data),
    .utx_ready(utx_ready),
    .bus      (bus.bridge_mp)
  );

  // Slot k owns byte k of the pin vectors
  for (genvar k = 0; k < dbg_pkg::num_slots; k++) begin : g_slot
    io_slot #(
      .slot_id(dbg_pkg::slot_w'(k))
    ) slot_i (
      .clk    (clk),
      .reset  (reset),
      .bus    (bus.slot_mp),
      .pin_in (gpio_in[k*dbg_pkg::data_w +: dbg_pkg::data_w]),
      .pin_out(out_regs[k]),
      .in_sync(in_regs[k])
    );
    assign gpio_out[k*dbg_pkg::data_w +: dbg_pkg::data_w] = out_regs[k];
  end

  io_read_mux read_mux_i (
    .clk     (clk),
    .reset   (reset),
    .bus     (bus.mux_mp),
    .out_regs(out_regs),
    .in_regs (in_regs)
  );

endmodule

// ==== tb/dbg_io_sva.sv ====
`timescale 1ns/100ps

module dbg_io_sva (
  input logic clk,
  input logic reset,
  input logic wen,
  input logic ren,
  input logic rdata_valid
);

  // A command is either a write or a read, never both at once
  wen_ren_exclusive: assert property (@(posedge clk) disable iff (reset) !(wen && ren))
    else $error("wen and ren are high in the same cycle");

  wen_single_pulse: assert property (@(posedge clk) disable iff (reset) wen |=> !wen)
    else $error("wen stayed high for more than one cycle");

  ren_single_pulse: assert property (@(posedge clk) disable iff (reset) ren |=> !ren)
    else $error("ren stayed high for more than one cycle");

  // The read mux answers exactly one cycle after the request
  ren_to_rdata_valid: assert property (@(posedge clk) disable iff (reset) ren |=> rdata_valid)
    else $error("rdata_valid did not follow ren by one cycle");

  rdata_valid_from_ren: assert property (
    @(posedge clk) disable iff (reset) rdata_valid |-> $past(ren)
  ) else $error("rdata_valid rose without a ren in the cycle before");

endmodule

bind dbg_bridge dbg_io_sva sva_i (
  .clk        (clk),
  .reset      (reset),
  .wen        (bus.wen),
  .ren        (bus.ren),
  .rdata_valid(bus.rdata_valid)
);

// ==== tb/tb_dbg_io_top.sv ====
`timescale 1ns/100ps

module tb_dbg_io_top;

  localparam int num_cmds = 200;
  // About 200 commands at up to 200 cycles each, with margin
  localparam int cycle_limit = 60000;

  logic clk;
  logic reset;
  logic uart_rx_pin;
  logic uart_tx_pin;
  logic [dbg_pkg::num_slots*dbg_pkg::data_w-1:0] gpio_in;
  logic [dbg_pkg::num_slots*dbg_pkg::data_w-1:0] gpio_out;

  logic [31:0] lcg_state;
  int cycle_count = 0;
  // Expected contents of each slot's output register
  logic [dbg_pkg::data_w-1:0] model_out [dbg_pkg::num_slots];

  dbg_io_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .uart_rx_pin(uart_rx_pin),
    .uart_tx_pin(uart_tx_pin),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    if (expected !== got) begin
      fail_now($sformatf("CHECK FAILED %s expected %h got %h", name, expected, got));
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      fail_now($sformatf("The run timed out after %0d cycles", cycle_limit));
    end
  end

  // Starts and ends 2 ns after a rising edge, then leaves two idle bits
  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    int i;
    frame = {1'b1, value, 1'b0};
    for (i = 0; i < 10; i++) begin
      uart_rx_pin = frame[i];
      repeat (dbg_pkg::clks_per_bit) @(posedge clk);
      #2;
    end
    uart_rx_pin = 1'b1;
    repeat (2 * dbg_pkg::clks_per_bit) @(posedge clk);
    #2;
  endtask

  // The line is looked at on falling edges, half a cycle away from DUT updates
  task automatic receive_byte(output logic [7:0] value);
    int i;
    @(negedge clk);
    while (uart_tx_pin !== 1'b0) begin
      @(negedge clk);
    end
    repeat (dbg_pkg::clks_per_bit / 2) @(negedge clk);
    if (uart_tx_pin !== 1'b0) begin
      fail_now("The reply start bit did not stay low until mid-bit");
    end
    for (i = 0; i < 8; i++) begin
      repeat (dbg_pkg::clks_per_bit) @(negedge clk);
      value[i] = uart_tx_pin;
    end
    repeat (dbg_pkg::clks_per_bit) @(negedge clk);
    if (uart_tx_pin !== 1'b1) begin
      fail_now("The reply stop bit was not high");
    end
  endtask

  task automatic check_all_slots();
    int k;
    for (k = 0; k < dbg_pkg::num_slots; k++) begin
      check_value($sformatf("gpio_out[%0d]", k), 32'(model_out[k]),
                  32'(gpio_out[k*dbg_pkg::data_w +: dbg_pkg::data_w]));
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0] cmd;
    logic [7:0] data;
    logic [7:0] expected;
    logic [7:0] reply;
    logic is_write;
    logic sel_in;
    int slot;
    int n;
    int k;

    lcg_state = 32'd34468;
    reset = 1'b1;
    uart_rx_pin = 1'b1;
    gpio_in = '0;
    for (k = 0; k < dbg_pkg::num_slots; k++) begin
      model_out[k] = '0;
    end

    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    @(posedge clk);
    #2;

    check_value("gpio_out", 32'h0, 32'(gpio_out));
    check_value("uart_tx_pin", 32'h1, 32'(uart_tx_pin));

    for (n = 0; n < num_cmds; n++) begin
      r = lcg_next();
      // Bits 5:2 keep their random value from the draw
      cmd = r[23:16];
      slot = int'(r[25:24]);
      is_write = r[29];
      sel_in = r[30];
      cmd[dbg_pkg::cmd_write_bit] = is_write;
      cmd[dbg_pkg::cmd_input_bit] = sel_in;
      cmd[dbg_pkg::slot_w-1:0] = 2'(slot);
      r = lcg_next();
      data = r[31:24];

      // Pins only move between commands, and settle before the next one
      gpio_in = lcg_next();
      repeat (4) @(posedge clk);
      #2;

      if (is_write) begin
        send_byte(cmd);
        send_byte(data);
        model_out[slot] = data;
        check_all_slots();
      end else begin
        if (sel_in) begin
          expected = gpio_in[slot*dbg_pkg::data_w +: dbg_pkg::data_w];
        end else begin
          expected = model_out[slot];
        end
        fork
          send_byte(cmd);
          receive_byte(reply);
        join
        check_value($sformatf("reply slot %0d sel_in %0d", slot, sel_in),
                    32'(expected), 32'(reply));
        @(posedge clk);
        #2;
      end
    end

    check_all_slots();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/dbg_pkg.sv
verilog/io_bus_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/dbg_bridge.sv
verilog/io_slot.sv
verilog/io_read_mux.sv
verilog/dbg_io_top.sv
tb/dbg_io_sva.sv
tb/tb_dbg_io_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_dbg_io_top -f vlog.f -o tb_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Test did not complete"; exit 1; }
exit 0
